/* list.f */
+incdir+test
design/div_pkg.sv
design/div_issue.sv
design/div_shift_core.sv
design/div_result_stage.sv
design/div_unit.sv
test/div_unit_tb.sv

/* test/div_unit_checks.svh */
// Included inside div_unit_tb; every task starts and ends 1 ns after a rising clock edge

// ==================================================
// Reset, model and compare helpers
// ==================================================

task automatic pulse_reset();
	rst = 1'b1;
	ld  = 1'b0;
	repeat (RST_CYCLES) @(posedge clk);
	#1;
	rst = 1'b0;
	// Nothing is held after reset, so the model forgets its key too
	key_vld = 1'b0;
endtask

// Behavioral divide in 64-bit arithmetic, truncating toward zero
function automatic div_rsp_t reference_div(input value_t a, input value_t b,
		input div_op_t op, input tag_t tag);
	div_rsp_t r;
	longint   ua;
	longint   ub;
	longint   sa;
	longint   sb;
	longint   q;
	longint   m;
	ua = a;
	ub = b;
	sa = ua - (a[VALUE_W-1] ? (longint'(1) << VALUE_W) : longint'(0));
	sb = ub - (b[VALUE_W-1] ? (longint'(1) << VALUE_W) : longint'(0));
	q = 0;
	m = 0;
	case (op)
		DIV_S: begin
			q = sa / sb;
			m = sa % sb;
		end
		DIV_SU: begin
			q = sa / ub;
			m = sa % ub;
		end
		default: begin
			q = ua / ub;
			m = ua % ub;
		end
	endcase
	r.tag  = tag;
	r.dvbz = (b == '0);
	// Zero divisor returns all ones and the raw dividend, never sign corrected
	r.quot = r.dvbz ? '1 : value_t'(q);
	r.rem  = r.dvbz ? a : value_t'(m);
	return r;
endfunction

task automatic rsp_compare(input div_rsp_t got, input div_rsp_t exp, input string what);
	if (got !== exp) begin
		chk_fail++;
		$display("mismatch at %0t: %s got q %h r %h z %b t %h, expected q %h r %h z %b t %h",
			$time, what, got.quot, got.rem, got.dvbz, got.tag,
			exp.quot, exp.rem, exp.dvbz, exp.tag);
	end else begin
		chk_pass++;
	end
endtask

task automatic latency_compare(input int got, input int exp, input string what);
	if (got != exp) begin
		chk_fail++;
		$display("mismatch at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
	end else begin
		chk_pass++;
	end
endtask

task automatic level_compare(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		chk_fail++;
		$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
	end else begin
		chk_pass++;
	end
endtask

task automatic report_test(input string name, input int fails_before);
	if (chk_fail == fails_before)
		$display("test %s finished without errors", name);
	else
		$display("test %s finished with %0d errors", name, chk_fail - fails_before);
endtask

// ==================================================
// One request from load to done
// ==================================================

task automatic issue_and_check(input value_t a, input value_t b, input div_op_t op);
	div_rsp_t exp;
	logic     hit;
	logic     early_idle;
	int       exp_cycles;
	int       cycles;
	string    what;
	// A repeat of the last started operands is answered in two cycles
	hit = key_vld && (a == key_a) && (b == key_b) && (op == key_op);
	exp_cycles = hit ? 2 : VALUE_W + 2;
	if (!hit) begin
		key_a   = a;
		key_b   = b;
		key_op  = op;
		key_vld = 1'b1;
	end
	exp  = reference_div(a, b, op, tag_seq);
	what = $sformatf("%s %h / %h tag %0d", op.name(), a, b, tag_seq);
	req.a   = a;
	req.b   = b;
	req.op  = op;
	req.tag = tag_seq;
	ld      = 1'b1;
	@(posedge clk);
	#1;
	ld = 1'b0;
	level_compare(idle, 1'b0, {what, " idle after load"});
	cycles = 0;
	early_idle = 1'b0;
	while (!done && cycles < DONE_LIMIT) begin
		@(posedge clk);
		#1;
		cycles++;
		// Idle must stay low until the cycle that brings done
		if (!done && idle)
			early_idle = 1'b1;
	end
	level_compare(early_idle, 1'b0, {what, " idle raised before done"});
	if (!done) begin
		chk_fail++;
		$display("no done arrived for %s within %0d cycles", what, DONE_LIMIT);
	end else begin
		latency_compare(cycles, exp_cycles, what);
		rsp_compare(rsp, exp, what);
		level_compare(idle, 1'b1, {what, " idle with done"});
	end
	tag_seq++;
endtask

// ==================================================
// Directed tests
// ==================================================

task automatic idle_after_reset();
	int fails;
	fails = chk_fail;
	level_compare(idle, 1'b1, "idle after reset");
	issue_and_check(32'd1000, 32'd33, DIV_U);
	// The same operands right after a new reset still take the full latency
	pulse_reset();
	level_compare(idle, 1'b1, "idle after second reset");
	issue_and_check(32'd1000, 32'd33, DIV_U);
	report_test("idle_after_reset", fails);
endtask

task automatic unsigned_divides();
	int     fails;
	value_t a;
	value_t b;
	fails = chk_fail;
	issue_and_check(32'd100, 32'd7, DIV_U);
	issue_and_check(32'hffff_ffff, 32'd1, DIV_U);
	issue_and_check(32'd5, 32'hffff_ffff, DIV_U);
	issue_and_check(32'hdead_beef, 32'h0000_1234, DIV_U);
	// Random divisors of varied size so quotients span many bit counts
	for (int i = 0; i < 8; i++) begin
		a = $urandom;
		b = $urandom >> ($urandom % VALUE_W);
		if (b == '0)
			b = 1;
		issue_and_check(a, b, DIV_U);
	end
	report_test("unsigned_divides", fails);
endtask

task automatic signed_divides();
	int fails;
	fails = chk_fail;
	issue_and_check(32'd100, 32'd7, DIV_S);
	issue_and_check(-32'sd100, 32'd7, DIV_S);
	issue_and_check(32'd100, -32'sd7, DIV_S);
	issue_and_check(-32'sd100, -32'sd7, DIV_S);
	// Most negative over minus one wraps back to itself
	issue_and_check(32'h8000_0000, 32'hffff_ffff, DIV_S);
	issue_and_check(32'h8000_0000, 32'd3, DIV_S);
	report_test("signed_divides", fails);
endtask

task automatic mixed_sign_divides();
	int fails;
	fails = chk_fail;
	// Divisors with the top bit set count as large positive values
	issue_and_check(-32'sd100, 32'h8000_0000, DIV_SU);
	issue_and_check(32'h8000_0000, 32'h8000_0000, DIV_SU);
	issue_and_check(32'hffff_ffff, 32'hffff_ffff, DIV_SU);
	report_test("mixed_sign_divides", fails);
endtask

task automatic zero_divisor_cases();
	int fails;
	fails = chk_fail;
	issue_and_check(32'd123, 32'd0, DIV_U);
	issue_and_check(-32'sd5, 32'd0, DIV_S);
	issue_and_check(32'h8000_0000, 32'd0, DIV_SU);
	report_test("zero_divisor_cases", fails);
endtask

task automatic repeated_operands();
	int fails;
	fails = chk_fail;
	issue_and_check(-32'sd100, -32'sd7, DIV_U);
	issue_and_check(-32'sd100, -32'sd7, DIV_S);
	// Two repeats with fresh tags, then only op changes
	issue_and_check(-32'sd100, -32'sd7, DIV_S);
	issue_and_check(-32'sd100, -32'sd7, DIV_S);
	issue_and_check(-32'sd100, -32'sd7, DIV_SU);
	report_test("repeated_operands", fails);
endtask

/* test/div_unit_tb.sv */
// Directed testbench for div_unit; the reference model needs VALUE_W below 64
`timescale 1ns/1ps

module div_unit_tb import div_pkg::*; ();

	// ==================================================
	// Run constants
	// ==================================================

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 10;
	localparam int SEED       = 32'h0eea_eed4;
	// Every divide and repeat issued by the test tasks below
	localparam int N_OPS      = 31;
	// A request that has not finished after this many cycles is lost
	localparam int DONE_LIMIT = VALUE_W + 10;
	localparam int WATCHDOG_NS = N_OPS * DONE_LIMIT * CLK_PERIOD
		+ 4 * RST_CYCLES * CLK_PERIOD + 1000;

	logic     clk;
	logic     rst;
	logic     ld;
	div_req_t req;
	div_rsp_t rsp;
	logic     done;
	logic     idle;

	// Check counters and the rolling request tag
	int   chk_pass;
	int   chk_fail;
	int   seed_val;
	tag_t tag_seq;

	// Model copy of the operands of the last started divide
	value_t  key_a;
	value_t  key_b;
	div_op_t key_op;
	logic    key_vld;

	div_unit dut_i (
		.clk  (clk),
		.rst  (rst),
		.ld   (ld),
		.req  (req),
		.rsp  (rsp),
		.done (done),
		.idle (idle)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	`include "div_unit_checks.svh"

	// Hard stop in case a wait loop never returns
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("sim failed");
		$finish;
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		clk      = 1'b0;
		rst      = 1'b1;
		ld       = 1'b0;
		req      = '0;
		chk_pass = 0;
		chk_fail = 0;
		tag_seq  = '0;
		key_vld  = 1'b0;
		seed_val = $urandom(SEED);
		pulse_reset();
		idle_after_reset();
		unsigned_divides();
		signed_divides();
		mixed_sign_divides();
		zero_divisor_cases();
		repeated_operands();
		$display("checks: %0d passed, %0d failed", chk_pass, chk_fail);
		if (chk_fail == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* design/div_unit.sv */
// No back-pressure; ld while idle is low is illegal, and rsp holds from done to the next done
`timescale 1ns/1ps

module div_unit import div_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     ld,
	input  div_req_t req,
	output div_rsp_t rsp,
	output logic     done,
	output logic     idle
);

	logic     start;
	logic     replay;
	logic     core_done;
	div_job_t job;
	tag_t     next_tag;
	value_t   quot_mag;
	value_t   rem_mag;

	// Request capture, repeat detection and busy tracking
	div_issue issue_i (
		.clk       (clk),
		.rst       (rst),
		.ld        (ld),
		.req       (req),
		.core_done (core_done),
		.start     (start),
		.replay    (replay),
		.job       (job),
		.next_tag  (next_tag),
		.idle      (idle)
	);

	// One quotient bit per cycle
	div_shift_core core_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.job       (job),
		.core_done (core_done),
		.quot_mag  (quot_mag),
		.rem_mag   (rem_mag)
	);

	// Signs, zero divisor and replay
	div_result_stage result_i (
		.clk       (clk),
		.rst       (rst),
		.core_done (core_done),
		.quot_mag  (quot_mag),
		.rem_mag   (rem_mag),
		.job       (job),
		.replay    (replay),
		.next_tag  (next_tag),
		.rsp       (rsp),
		.done      (done)
	);

endmodule

/* design/div_result_stage.sv */
// Response stays valid until the next done; a zero divisor skips sign correction entirely
`timescale 1ns/1ps

module div_result_stage import div_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     core_done,
	input  value_t   quot_mag,
	input  value_t   rem_mag,
	input  div_job_t job,
	input  logic     replay,
	input  tag_t     next_tag,
	output div_rsp_t rsp,
	output logic     done
);

	value_t quot_fix;
	value_t rem_fix;

	// ==================================================
	// Sign correction and zero divisor rule
	// ==================================================

	always_comb begin
		if (job.dvbz) begin
			// All ones and the raw dividend, for every operation
			quot_fix = '1;
			rem_fix  = job.dividend;
		end else begin
			// Truncation toward zero falls out of negating the magnitudes
			quot_fix = job.neg_quot ? -quot_mag : quot_mag;
			rem_fix  = job.neg_rem ? -rem_mag : rem_mag;
		end
	end

	// ==================================================
	// Held response
	// ==================================================

	// The last result stays here so that a repeat can be answered from it
	always_ff @(posedge clk) begin
		if (core_done) begin
			rsp.quot <= quot_fix;
			rsp.rem  <= rem_fix;
			rsp.dvbz <= job.dvbz;
			rsp.tag  <= job.tag;
		end else if (replay) begin
			// Only the tag changes on a repeat
			rsp.tag <= next_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			done <= 1'b0;
		else
			done <= core_done || replay;
	end

	// Issue never replays while the core is finishing a job
	a_replay_vs_core: assert property (@(posedge clk) disable iff (rst)
		!(replay && core_done));

endmodule

/* design/div_shift_core.sv */
// Unsigned magnitudes only; job must stay stable for the VALUE_W cycles after start
`timescale 1ns/1ps

module div_shift_core import div_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  div_job_t job,
	output logic     core_done,
	output value_t   quot_mag,
	output value_t   rem_mag
);

	// Partial remainder is one bit wider so the trial subtract shows its sign
	logic [VALUE_W:0] prem;
	// Holds the dividend bits still to come and collects quotient bits behind them
	value_t           quot;
	logic [CNT_W-1:0] cnt;
	logic             running;
	logic [VALUE_W:0] shifted;
	logic [VALUE_W:0] diff;

	// ==================================================
	// One restoring step
	// ==================================================

	// Bring the next dividend bit into the remainder
	assign shifted = {prem[VALUE_W-1:0], quot[VALUE_W-1]};
	// A set top bit means the divisor did not fit
	assign diff = shifted - {1'b0, job.divisor_mag};

	// ==================================================
	// Control
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			running   <= 1'b0;
			core_done <= 1'b0;
			cnt       <= '0;
		end else begin
			core_done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				cnt     <= CNT_W'(VALUE_W);
			end else if (running) begin
				cnt <= cnt - CNT_W'(1);
				// Last step lands together with the done pulse
				if (cnt == CNT_W'(1)) begin
					running   <= 1'b0;
					core_done <= 1'b1;
				end
			end
		end
	end

	// ==================================================
	// Datapath
	// ==================================================

	always_ff @(posedge clk) begin
		if (start) begin
			prem <= '0;
			quot <= job.dividend_mag;
		end else if (running) begin
			if (!diff[VALUE_W]) begin
				prem <= diff;
				quot <= {quot[VALUE_W-2:0], 1'b1};
			end else begin
				// Restore by keeping the shifted value
				prem <= shifted;
				quot <= {quot[VALUE_W-2:0], 1'b0};
			end
		end
	end

	assign quot_mag = quot;
	assign rem_mag  = prem[VALUE_W-1:0];

	// The issue block must not restart the engine mid-divide
	a_start_while_running: assert property (@(posedge clk) disable iff (rst)
		start |-> !running);

	// Done follows start after one step per bit and lasts a single cycle
	a_done_one_cycle: assert property (@(posedge clk) disable iff (rst)
		start |-> ##(VALUE_W + 1) core_done ##1 !core_done);

endmodule

/* design/div_issue.sv */
// A load is legal only while idle is high; a repeat of the last started a, b and op is replayed
`timescale 1ns/1ps

module div_issue import div_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     ld,
	input  div_req_t req,
	input  logic     core_done,
	output logic     start,
	output logic     replay,
	output div_job_t job,
	output tag_t     next_tag,
	output logic     idle
);

	// Key of the last started job
	value_t   key_a;
	value_t   key_b;
	div_op_t  key_op;
	logic     key_vld;

	logic     hit;
	logic     rep_pend;
	logic     busy;
	logic     a_neg;
	logic     b_neg;
	value_t   a_abs;
	value_t   b_abs;
	div_job_t job_d;

	// ==================================================
	// Repeat detection and operand preparation
	// ==================================================

	// The key only counts once a job has been started since reset
	assign hit = key_vld && (req.a == key_a) && (req.b == key_b) && (req.op == key_op);

	assign a_neg = req.a[VALUE_W-1];
	assign b_neg = req.b[VALUE_W-1];
	// Negating the most negative value gives back its own unsigned magnitude
	assign a_abs = a_neg ? -req.a : req.a;
	assign b_abs = b_neg ? -req.b : req.b;

	always_comb begin
		// Raw dividend and tag go along unchanged
		job_d.dividend = req.a;
		job_d.tag      = req.tag;
		job_d.dvbz     = (req.b == '0);
		case (req.op)
			DIV_S: begin
				job_d.dividend_mag = a_abs;
				job_d.divisor_mag  = b_abs;
				job_d.neg_quot     = a_neg ^ b_neg;
				job_d.neg_rem      = a_neg;
			end
			DIV_SU: begin
				// Divisor is taken as unsigned even with its top bit set
				job_d.dividend_mag = a_abs;
				job_d.divisor_mag  = req.b;
				job_d.neg_quot     = a_neg;
				job_d.neg_rem      = a_neg;
			end
			default: begin
				job_d.dividend_mag = req.a;
				job_d.divisor_mag  = req.b;
				job_d.neg_quot     = 1'b0;
				job_d.neg_rem      = 1'b0;
			end
		endcase
	end

	// ==================================================
	// Sequencing
	// ==================================================

	// Replay waits one extra cycle so that a repeat completes two cycles after the load
	always_ff @(posedge clk) begin
		if (rst) begin
			start    <= 1'b0;
			rep_pend <= 1'b0;
			replay   <= 1'b0;
			key_vld  <= 1'b0;
			busy     <= 1'b0;
		end else begin
			start    <= ld && !hit;
			rep_pend <= ld && hit;
			replay   <= rep_pend;
			if (ld && !hit)
				key_vld <= 1'b1;
			// Busy drops on the same edge that raises done downstream
			if (ld)
				busy <= 1'b1;
			else if (core_done || replay)
				busy <= 1'b0;
		end
	end

	// Key and job are loaded together whenever a new divide starts
	always_ff @(posedge clk) begin
		if (ld && !hit) begin
			key_a  <= req.a;
			key_b  <= req.b;
			key_op <= req.op;
			job    <= job_d;
		end
		if (ld)
			next_tag <= req.tag;
	end

	assign idle = !busy;

	// No load may arrive while a job or a replay is in flight
	a_ld_while_busy: assert property (@(posedge clk) disable iff (rst) ld |-> !busy);

endmodule

/* design/div_pkg.sv */
// Shared widths, opcodes and structs of the divide unit; VALUE_W must stay below 2**CNT_W
package div_pkg;

	// ==================================================
	// Widths
	// ==================================================

	// Operand and result width
	localparam int VALUE_W = 32;

	// Bit counter width that can hold VALUE_W itself
	localparam int CNT_W = 6;

	typedef logic [VALUE_W-1:0] value_t;

	// Request tag that is passed through untouched
	typedef logic [3:0] tag_t;

	// ==================================================
	// Operation codes
	// ==================================================

	// Unsigned, signed, and signed dividend over unsigned divisor
	typedef enum logic [1:0] {
		DIV_U  = 2'd0,
		DIV_S  = 2'd1,
		DIV_SU = 2'd2
	} div_op_t;

	// ==================================================
	// Request, job and response
	// ==================================================

	// One request as presented with the load strobe
	typedef struct packed {
		value_t  a;
		value_t  b;
		div_op_t op;
		tag_t    tag;
	} div_req_t;

	// Prepared job, held by the issue block until the next start
	typedef struct packed {
		value_t dividend_mag;
		value_t divisor_mag;
		logic   neg_quot;
		logic   neg_rem;
		logic   dvbz;
		value_t dividend;
		tag_t   tag;
	} div_job_t;

	// Final result returned with done
	typedef struct packed {
		value_t quot;
		value_t rem;
		logic   dvbz;
		tag_t   tag;
	} div_rsp_t;

endpackage
